//--- common/emesh_pkg.sv
// emesh package with the packet layout, address fields and mailbox group code
`default_nettype none

package emesh_pkg;

   // packet and address sizes
   localparam int emesh_pw = 104;                  // full packet width
   localparam int emesh_aw = 32;                   // address width

   typedef logic [emesh_aw-1:0] emesh_addr_t;      // destination address

   // address field positions
   localparam int id_lsb  = 20;                    // link id starts here
   localparam int id_w    = 12;                    // link id in bits 31..20
   localparam int grp_lsb = 8;                     // register group field
   localparam int grp_w   = 3;                     // group in bits 10..8

   typedef logic [id_w-1:0] link_id_t;             // link id of a mesh node

   localparam logic [grp_w-1:0] mailbox_group = 3'd3;  // mailbox register group

   // packet layout with the msb first
   // the payload takes whatever is left above addr, ctrl, write and spare
   typedef struct packed {
      logic [emesh_pw-emesh_aw-9:0] data;         // 64 bit payload, bits 103..40
      emesh_addr_t                  addr;         // bits 39..8
      logic [5:0]                   ctrl;         // routing and size control
      logic                         write;        // bit 1 set for a write
      logic                         spare;        // bit 0 unused
   } emesh_packet_t;

endpackage

`default_nettype wire

//--- common/mailbox_pkg.sv
// mailbox package with widths, fifo depth, register offsets and entry types
`default_nettype none

package mailbox_pkg;

   // data words
   localparam int mbox_dw = 32;                    // one mi word
   typedef logic [2*mbox_dw-1:0] mbox_entry_t;     // hi word over lo word

   // register address on the mi port
   localparam int rfaw    = 6;                     // register field width
   localparam int reg_lsb = 2;                     // byte offset below it

   typedef logic [rfaw+reg_lsb-1:0] mi_addr_t;     // 8 bit mi address
   typedef logic [rfaw-1:0]         reg_offset_t;  // register select, bits 7..2

   localparam reg_offset_t mailbox_lo_offset = 6'h09;  // full entry, no pop
   localparam reg_offset_t mailbox_hi_offset = 6'h0a;  // upper word, pops

   // fifo sizing
   localparam int fifo_aw    = 5;                  // entry index bits
   localparam int fifo_depth = 1 << fifo_aw;       // 32 entries

   typedef logic [fifo_aw:0] fifo_ptr_t;           // index plus wrap bit

   // push from the write side
   typedef struct packed {
      logic        push;                           // one cycle strobe
      mbox_entry_t entry;                          // payload to store
   } mbox_push_t;

endpackage

`default_nettype wire

//--- hw/mailbox_write_decode.sv
// mailbox write decode, accepts emesh writes to the mailbox and registers a push
`timescale 1ns/1ps
`default_nettype none

module mailbox_write_decode
   import emesh_pkg::*;
   import mailbox_pkg::*;
#(
   parameter link_id_t link_id = 12'h000           // id this link answers to
) (
   input  wire                wr_clk,
   input  wire                arst_n,
   input  wire                emesh_access,        // packet valid strobe
   input  wire emesh_packet_t emesh_packet,
   output mbox_push_t         wr_push              // registered push to fifo
);

   emesh_addr_t pkt_addr;                          // address of current packet
   logic        id_hit;                            // addressed to this link
   logic        grp_hit;                           // mailbox group
   logic        reg_hit;                           // low mailbox register
   logic        accept;                            // all checks pass
   logic        push_q;                            // push strobe flop
   mbox_entry_t entry_q;                           // payload flop

   assign pkt_addr = emesh_packet.addr;

   assign id_hit  = pkt_addr[id_lsb +: id_w] == link_id;
   assign grp_hit = pkt_addr[grp_lsb +: grp_w] == mailbox_group;
   assign reg_hit = pkt_addr[reg_lsb +: rfaw] == mailbox_lo_offset;

   // only writes to the low mailbox register go into the fifo
   assign accept = emesh_access & emesh_packet.write & id_hit & grp_hit & reg_hit;

   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         push_q <= 1'b0;
      end else begin
         push_q <= accept;                         // one strobe per packet
      end
   end

   always_ff @(posedge wr_clk) begin
      if (accept) begin
         entry_q <= emesh_packet.data;             // hold payload for the push
      end
   end

   assign wr_push.push  = push_q;
   assign wr_push.entry = entry_q;

endmodule

`default_nettype wire

//--- async_fifo/async_fifo.sv
// dual clock mailbox fifo with gray pointers, two flop synchronizers and flags
`timescale 1ns/1ps
`default_nettype none

module async_fifo
   import mailbox_pkg::*;
(
   input  wire             wr_clk,
   input  wire             rd_clk,
   input  wire             arst_n,
   input  wire mbox_push_t wr_push,                // push strobe and entry
   input  wire             pop,                    // advance the head
   output mbox_entry_t     rd_data,                // head entry, always shown
   output logic            empty,
   output logic            full
);

   mbox_entry_t mem [fifo_depth];                  // entry storage

   // write domain
   fifo_ptr_t wr_bin;                              // binary write pointer
   fifo_ptr_t wr_bin_next;
   fifo_ptr_t wr_gray;                             // gray write pointer
   fifo_ptr_t wr_gray_next;
   fifo_ptr_t rd_gray_s1;                          // read pointer, first flop
   fifo_ptr_t rd_gray_s2;                          // read pointer in wr domain
   logic      wr_en;
   logic      full_next;

   // read domain
   fifo_ptr_t rd_bin;                              // binary read pointer
   fifo_ptr_t rd_bin_next;
   fifo_ptr_t rd_gray;                             // gray read pointer
   fifo_ptr_t rd_gray_next;
   fifo_ptr_t wr_gray_s1;                          // write pointer, first flop
   fifo_ptr_t wr_gray_s2;                          // write pointer in rd domain
   logic      rd_en;
   logic      empty_next;

   // write side

   assign wr_en        = wr_push.push & ~full;     // drop push when full
   assign wr_bin_next  = wr_bin + fifo_ptr_t'(wr_en);
   assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

   // full when the write pointer is one lap ahead of the read pointer
   // in gray code that means the top two bits differ and the rest match
   assign full_next = wr_gray_next == {~rd_gray_s2[fifo_aw -: 2], rd_gray_s2[fifo_aw-2:0]};

   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
         full    <= 1'b0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_gray_next;
         full    <= full_next;                     // set on the last free slot
      end
   end

   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;                    // crossing from rd_clk
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_bin[fifo_aw-1:0]] <= wr_push.entry;
      end
   end

   // read side

   assign rd_en        = pop & ~empty;             // ignore pop when empty
   assign rd_bin_next  = rd_bin + fifo_ptr_t'(rd_en);
   assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;
   assign empty_next   = rd_gray_next == wr_gray_s2;

   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
         empty   <= 1'b1;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_gray_next;
         empty   <= empty_next;                    // clears once write ptr lands
      end
   end

   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;                    // crossing from wr_clk
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign rd_data = mem[rd_bin[fifo_aw-1:0]];      // first word fall through

endmodule

`default_nettype wire

//--- hw/mailbox_read_port.sv
// mailbox read port, decodes mi reads into registered data and pops on hi reads
`timescale 1ns/1ps
`default_nettype none

module mailbox_read_port
   import mailbox_pkg::*;
(
   input  wire              rd_clk,
   input  wire              arst_n,
   input  wire              mi_en,                 // mi access strobe
   input  wire              mi_we,                 // write, ignored here
   input  wire mi_addr_t    mi_addr,
   input  wire mbox_entry_t rd_data,               // fifo head entry
   input  wire              empty,
   output logic             pop,                   // fifo read strobe
   output mbox_entry_t      mi_dout                // registered read data
);

   logic        mi_rd;                             // read access
   reg_offset_t reg_sel;                           // register field of address
   mbox_entry_t dout_next;

   assign mi_rd   = mi_en & ~mi_we;
   assign reg_sel = mi_addr[reg_lsb +: rfaw];

   // reading the high word retires the entry
   assign pop = mi_rd & (reg_sel == mailbox_hi_offset) & ~empty;

   always_comb begin
      dout_next = '0;                              // zero unless a mailbox read
      if (mi_rd) begin
         case (reg_sel)
            mailbox_lo_offset: begin
               dout_next = rd_data;                // whole 64 bit entry
            end
            mailbox_hi_offset: begin
               dout_next = {2{rd_data[2*mbox_dw-1 -: mbox_dw]}};  // hi word twice
            end
            default: begin
               dout_next = '0;                     // other registers not here
            end
         endcase
      end
   end

   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         mi_dout <= '0;
      end else begin
         mi_dout <= dout_next;                     // valid one cycle after mi_en
      end
   end

endmodule

`default_nettype wire

//--- hw/emailbox_top.sv
// mailbox top level joining write decode, dual clock fifo and mi read port
`timescale 1ns/1ps
`default_nettype none

module emailbox_top
   import emesh_pkg::*;
   import mailbox_pkg::*;
#(
   parameter link_id_t link_id = 12'h000           // id this link answers to
) (
   input  wire                wr_clk,              // emesh side clock
   input  wire                rd_clk,              // mi side clock
   input  wire                arst_n,
   input  wire                emesh_access,
   input  wire emesh_packet_t emesh_packet,
   input  wire                mi_en,
   input  wire                mi_we,
   input  wire mi_addr_t      mi_addr,
   output mbox_entry_t        mi_dout,
   output logic               mailbox_full,
   output logic               mailbox_not_empty    // level interrupt
);

   mbox_push_t  wr_push;                           // decode to fifo
   mbox_entry_t fifo_head;                         // fifo to read port
   logic        fifo_empty;
   logic        fifo_pop;                          // read port to fifo

   mailbox_write_decode #(
      .link_id (link_id)
   ) u_decode (
      .wr_clk       (wr_clk),
      .arst_n       (arst_n),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .wr_push      (wr_push)
   );

   async_fifo u_fifo (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .arst_n  (arst_n),
      .wr_push (wr_push),
      .pop     (fifo_pop),
      .rd_data (fifo_head),
      .empty   (fifo_empty),
      .full    (mailbox_full)
   );

   mailbox_read_port u_read_port (
      .rd_clk  (rd_clk),
      .arst_n  (arst_n),
      .mi_en   (mi_en),
      .mi_we   (mi_we),
      .mi_addr (mi_addr),
      .rd_data (fifo_head),
      .empty   (fifo_empty),
      .pop     (fifo_pop),
      .mi_dout (mi_dout)
   );

   assign mailbox_not_empty = ~fifo_empty;         // interrupt while entries wait

endmodule

`default_nettype wire

//--- tb/emailbox_checker.sv
// mailbox fifo checker, concurrent assertions on the flags and pointers
`timescale 1ns/1ps
`default_nettype none

module emailbox_checker
   import mailbox_pkg::*;
(
   input wire            wr_clk,
   input wire            rd_clk,
   input wire            arst_n,
   input wire            full,
   input wire            empty,
   input wire fifo_ptr_t wr_bin,
   input wire fifo_ptr_t wr_gray,
   input wire fifo_ptr_t rd_bin,
   input wire fifo_ptr_t rd_gray
);

   logic flags_bad  = 1'b0;                  // set by a failing assertion
   logic write_bad  = 1'b0;
   logic rd_rst_bad = 1'b0;
   logic wr_rst_bad = 1'b0;
   logic fail_seen;                          // any of the above

   assign fail_seen = flags_bad | write_bad | rd_rst_bad | wr_rst_bad;

   // 32 entries take longer to fill or drain than either synchronizer needs
   a_flags_exclusive: assert property (@(posedge rd_clk) disable iff (!arst_n)
      !(full && empty))
      else begin
         $error("fifo full and empty at the same time");
         flags_bad = 1'b1;
      end

   // a write while full would put one entry more than the depth in flight
   a_no_overrun: assert property (@(posedge wr_clk) disable iff (!arst_n)
      fifo_ptr_t'(wr_bin - rd_bin) <= fifo_ptr_t'(fifo_depth))
      else begin
         $error("fifo written while full");
         write_bad = 1'b1;
      end

   a_rd_ptr_reset: assert property (@(posedge rd_clk)
      !arst_n |-> (rd_bin == '0 && rd_gray == '0))
      else begin
         $error("read pointers not zero in reset");
         rd_rst_bad = 1'b1;
      end

   a_wr_ptr_reset: assert property (@(posedge wr_clk)
      !arst_n |-> (wr_bin == '0 && wr_gray == '0))
      else begin
         $error("write pointers not zero in reset");
         wr_rst_bad = 1'b1;
      end

endmodule

`default_nettype wire

//--- tb/tb_emailbox.sv
// mailbox testbench, table driven, with a queue model of the fifo contents
`timescale 1ns/1ps
`default_nettype none

module tb_emailbox
   import emesh_pkg::*;
   import mailbox_pkg::*;
;

   localparam link_id_t    dut_id          = 12'h5A3;
   localparam logic [2:0]  grp_mb          = mailbox_group;
   localparam reg_offset_t off_lo          = mailbox_lo_offset;
   localparam reg_offset_t off_hi          = mailbox_hi_offset;
   localparam int          max_wait        = 20;    // rd_clk cycles for a flag to move
   localparam int          settle_cycles   = 8;     // flags then have to hold
   localparam int          overflow_cycles = 400;   // 33 writes and a full drain

   typedef enum logic [2:0] {op_send, op_rd_lo, op_rd_hi, op_rd_other, op_wait} op_t;

   typedef struct packed {
      op_t         op;
      logic        access;                          // emesh_access of a send
      logic        write;                           // packet write bit, or mi_we
      link_id_t    id;
      logic [2:0]  grp;
      reg_offset_t off;                             // packet or mi register
      logic        accept;                          // send should reach the fifo
   } stim_t;

   logic          wr_clk;
   logic          rd_clk;
   logic          arst_n;
   logic          emesh_access;
   emesh_packet_t emesh_packet;
   logic          mi_en;
   logic          mi_we;
   mi_addr_t      mi_addr;
   mbox_entry_t   mi_dout;
   logic          mailbox_full;
   logic          mailbox_not_empty;

   stim_t       stims [$];                          // stimulus table
   mbox_entry_t model [$];                          // expected fifo contents
   integer      seed = 32'h573;
   int          cycle_count = 0;
   int          timeout_cycles = 0;

   emailbox_top #(
      .link_id (dut_id)
   ) u_dut (
      .wr_clk            (wr_clk),
      .rd_clk            (rd_clk),
      .arst_n            (arst_n),
      .emesh_access      (emesh_access),
      .emesh_packet      (emesh_packet),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_dout           (mi_dout),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   bind async_fifo emailbox_checker u_checker (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .arst_n  (arst_n),
      .full    (full),
      .empty   (empty),
      .wr_bin  (wr_bin),
      .wr_gray (wr_gray),
      .rd_bin  (rd_bin),
      .rd_gray (rd_gray)
   );

   always #50 rd_clk = ~rd_clk;                     // 100 ns
   always #65 wr_clk = ~wr_clk;                     // 130 ns, unrelated to rd_clk

   always @(posedge rd_clk) begin
      cycle_count <= cycle_count + 1;
      if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
         $display("timeout, the simulation hung after %0d rd_clk cycles", cycle_count);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
   end

   task report_failure(input string msg);
      $display("** Error (%0d ns): %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
   endtask

   always @(posedge rd_clk) begin
      if (u_dut.u_fifo.u_checker.fail_seen === 1'b1) begin
         report_failure("a bound fifo assertion failed");  // fifo checker tripped
      end
   end

   function automatic stim_t make_stim(op_t op, logic access, logic write, link_id_t id,
                                       logic [2:0] grp, reg_offset_t off, logic accept);
      return '{op, access, write, id, grp, off, accept};
   endfunction

   task automatic add_stim(op_t op, logic access, logic write, link_id_t id,
                           logic [2:0] grp, reg_offset_t off, logic accept);
      stims.push_back(make_stim(op, access, write, id, grp, off, accept));
   endtask

   task automatic load_table();
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // idle after reset
      add_stim(op_send,     1'b0, 1'b1, dut_id,  grp_mb, off_lo, 1'b0);  // access low
      add_stim(op_send,     1'b1, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // read packet
      add_stim(op_send,     1'b1, 1'b1, 12'h5A4, grp_mb, off_lo, 1'b0);  // other link
      add_stim(op_send,     1'b1, 1'b1, dut_id,  3'd2,   off_lo, 1'b0);  // other group
      add_stim(op_send,     1'b1, 1'b1, dut_id,  grp_mb, off_hi, 1'b0);  // hi offset
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // still empty
      add_stim(op_send,     1'b1, 1'b1, dut_id,  grp_mb, off_lo, 1'b1);
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // interrupt up
      add_stim(op_rd_lo,    1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);
      add_stim(op_rd_lo,    1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // same entry
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // lo did not pop
      add_stim(op_send,     1'b1, 1'b1, dut_id,  grp_mb, off_lo, 1'b1);
      add_stim(op_send,     1'b1, 1'b1, dut_id,  grp_mb, off_lo, 1'b1);
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);
      add_stim(op_rd_other, 1'b0, 1'b0, dut_id,  grp_mb, 6'h08,  1'b0);
      add_stim(op_rd_hi,    1'b0, 1'b1, dut_id,  grp_mb, off_hi, 1'b0);  // mi write
      add_stim(op_rd_hi,    1'b0, 1'b0, dut_id,  grp_mb, off_hi, 1'b0);
      add_stim(op_rd_lo,    1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);
      add_stim(op_rd_hi,    1'b0, 1'b0, dut_id,  grp_mb, off_hi, 1'b0);
      add_stim(op_rd_hi,    1'b0, 1'b0, dut_id,  grp_mb, off_hi, 1'b0);  // last entry
      add_stim(op_wait,     1'b0, 1'b0, dut_id,  grp_mb, off_lo, 1'b0);  // interrupt down
      add_stim(op_rd_other, 1'b0, 1'b0, dut_id,  grp_mb, 6'h0b,  1'b0);
   endtask

   task automatic send_packet(input stim_t s);
      emesh_packet_t pkt;
      mbox_entry_t   payload;
      payload                    = {$random(seed), $random(seed)};
      pkt                        = '0;
      pkt.data                   = payload;
      pkt.addr[id_lsb +: id_w]   = s.id;            // link id, bits 31..20
      pkt.addr[grp_lsb +: grp_w] = s.grp;           // group, bits 10..8
      pkt.addr[reg_lsb +: rfaw]  = s.off;           // register, bits 7..2
      pkt.write                  = s.write;
      @(negedge wr_clk);
      emesh_access = s.access;
      emesh_packet = pkt;
      @(negedge wr_clk);
      emesh_access = 1'b0;
      emesh_packet = '0;
      if (s.accept) begin
         model.push_back(payload);
      end
   endtask

   task automatic mi_read(input stim_t s);
      mbox_entry_t        expected;
      logic [mbox_dw-1:0] hi_word;
      logic               is_read;
      is_read  = !s.write;                          // mi_we high is a write
      expected = '0;
      if (is_read && s.op == op_rd_lo) begin
         expected = model[0];
      end else if (is_read && s.op == op_rd_hi) begin
         hi_word  = model[0][63:32];                // upper word of the head entry
         expected = {hi_word, hi_word};             // seen in both halves
      end
      @(negedge rd_clk);
      mi_en   = 1'b1;
      mi_we   = s.write;
      mi_addr = {s.off, 2'b00};
      @(negedge rd_clk);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
      mi_addr = '0;
      assert (mi_dout === expected)
         else report_failure($sformatf("%s at offset %h gave %h, expected %h",
                                       s.op.name(), s.off, mi_dout, expected));
      if (is_read && s.op == op_rd_hi) begin
         void'(model.pop_front());                  // hi read retires the entry
      end
      @(negedge rd_clk);
      assert (mi_dout === '0)
         else report_failure($sformatf("mi_dout %h after an idle cycle", mi_dout));
   endtask

   task automatic wait_flags();
      logic exp_ne;
      logic exp_full;
      int   polls;
      exp_ne   = model.size() != 0;
      exp_full = model.size() == fifo_depth;
      polls    = 0;
      @(negedge rd_clk);
      while ((mailbox_not_empty !== exp_ne || mailbox_full !== exp_full) &&
             polls < max_wait) begin
         @(negedge rd_clk);
         polls++;
      end
      assert (mailbox_not_empty === exp_ne && mailbox_full === exp_full)
         else report_failure($sformatf("flags never reached not_empty %0b full %0b",
                                       exp_ne, exp_full));
      repeat (settle_cycles) begin
         @(negedge rd_clk);
         assert (mailbox_not_empty === exp_ne && mailbox_full === exp_full)
            else report_failure($sformatf("flags left not_empty %0b full %0b",
                                          exp_ne, exp_full));
      end
   endtask

   task automatic apply_stim(input stim_t s);
      case (s.op)
         op_send: send_packet(s);
         op_wait: wait_flags();
         default: mi_read(s);
      endcase
   endtask

   task automatic run_overflow();
      for (int i = 0; i <= fifo_depth; i++) begin
         send_packet(make_stim(op_send, 1'b1, 1'b1, dut_id, grp_mb, off_lo,
                               model.size() < fifo_depth));  // 33rd gets dropped
         if (i == fifo_depth - 1) begin
            wait_flags();                           // full before the extra write
         end
      end
      wait_flags();
      for (int i = 0; i < fifo_depth; i++) begin
         mi_read(make_stim(op_rd_hi, 1'b0, 1'b0, dut_id, grp_mb, off_hi, 1'b0));
         if (i == 0) begin
            wait_flags();                           // full clears after one pop
         end
      end
      wait_flags();                                 // exactly 32 came back
   endtask

   initial begin
      rd_clk       = 1'b0;
      wr_clk       = 1'b0;
      arst_n       = 1'b1;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      load_table();
      timeout_cycles = stims.size() * 40 + overflow_cycles;
      #10;
      arst_n = 1'b0;
      repeat (4) @(posedge rd_clk);
      @(negedge rd_clk);
      arst_n = 1'b1;
      assert (mi_dout === '0 && mailbox_not_empty === 1'b0 && mailbox_full === 1'b0)
         else report_failure("outputs not at their reset values");
      foreach (stims[i]) begin
         apply_stim(stims[i]);
      end
      run_overflow();
      if (u_dut.u_fifo.u_checker.fail_seen === 1'b0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         report_failure("a bound fifo assertion failed");
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
common/emesh_pkg.sv
common/mailbox_pkg.sv
hw/mailbox_write_decode.sv
async_fifo/async_fifo.sv
hw/mailbox_read_port.sv
hw/emailbox_top.sv
tb/emailbox_checker.sv
tb/tb_emailbox.sv

//--- run_sim.sh
#!/bin/sh
# build the mailbox testbench with verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --assert -j 0 --top-module tb_emailbox -f filelist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_emailbox 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
echo "pass message not found in the simulation output"
exit 1
